// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := hdmi_display_tb
FILELIST   := filelist.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== dv/hdmi_display_sva.sv ====
// concurrent assertions on sync decode and encoder disparity
`default_nettype none

module hdmi_display_sva #(
    parameter bit ENCODER = 1'b0
) (
    input wire logic              pixel_clk,
    input wire logic              external_resetn,
    input wire logic              de_i,
    input wire logic              hsync_i,
    input wire logic              vsync_i,
    input wire logic signed [4:0] disparity_i
);

    if (ENCODER) begin : g_encoder
        // running disparity bound during data
        disparity_bounded: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
            de_i |-> ((disparity_i <= 5'sd8) && (disparity_i >= -5'sd8)))
            else $error("running disparity outside +/-8");

        disparity_cleared: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
            !de_i |=> (disparity_i == 5'sd0))
            else $error("disparity not cleared by blanking");
    end else begin : g_timing
        // syncs only ever sit in blanking
        hsync_not_in_active: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
            !(hsync_i && de_i))
            else $error("hsync high while de is high");

        vsync_not_in_active: assert property (@(posedge pixel_clk) disable iff (!external_resetn)
            !(vsync_i && de_i))
            else $error("vsync high while de is high");
    end

endmodule

bind video_timing hdmi_display_sva #(.ENCODER(1'b0)) u_timing_sva (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .de_i            (sync_o.de),
    .hsync_i         (sync_o.hsync),
    .vsync_i         (sync_o.vsync),
    .disparity_i     (5'sd0)
);

bind tmds_encoder hdmi_display_sva #(.ENCODER(1'b1)) u_enc_sva (
    .pixel_clk       (pixel_clk),
    .external_resetn (external_resetn),
    .de_i            (tin_i.de),
    .hsync_i         (1'b0),
    .vsync_i         (1'b0),
    .disparity_i     (disparity)
);

`default_nettype wire

// ==== dv/hdmi_display_tb.sv ====
// testbench with directed tests, tmds decoding reference, xorshift stimulus and timeout
`default_nettype none

`include "hdmi_defines.svh"

module hdmi_display_tb
    import hdmi_pkg::*;
;

    localparam int FRAME_CYCLES = `H_TOTAL * `V_TOTAL;
    // about six frames of scanning plus all the fills, with margin
    localparam int TIMEOUT_CYCLES = 4000;

    logic      pixel_clk;
    logic      external_resetn;
    fb_write_t fb_wr;
    tmds_sym_t tmds;
    tmds_sym_t sym;
    rgb_t      exp_mem [`FB_DEPTH];
    logic [31:0] rng_state;
    int        cycle_cnt;

    hdmi_display_top dut (
        .pixel_clk       (pixel_clk),
        .external_resetn (external_resetn),
        .fb_wr_i         (fb_wr),
        .tmds_o          (tmds)
    );

    always #50 pixel_clk = ~pixel_clk;

    always @(posedge pixel_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Verification failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // control symbols are looked up, never decoded bitwise
    function automatic logic is_ctrl(input logic [9:0] s);
        return (s == `CTRL_00) || (s == `CTRL_01) || (s == `CTRL_10) || (s == `CTRL_11);
    endfunction

    // {vsync, hsync} carried by a control symbol
    function automatic logic [1:0] ctrl_syncs(input logic [9:0] s);
        logic [1:0] r;
        r = 2'b00;
        if (s == `CTRL_01) r = 2'b01;
        if (s == `CTRL_10) r = 2'b10;
        if (s == `CTRL_11) r = 2'b11;
        return r;
    endfunction

    // bit 9 undoes inversion, bit 8 picks xor or xnor recovery
    function automatic logic [7:0] decode_byte(input logic [9:0] s);
        logic [7:0] q;
        logic [7:0] b;
        q = s[9] ? ~s[7:0] : s[7:0];
        b[0] = q[0];
        for (int i = 1; i < 8; i++) begin
            b[i] = s[8] ? (q[i] ^ q[i-1]) : ~(q[i] ^ q[i-1]);
        end
        return b;
    endfunction

    function automatic int ones_minus_zeros(input logic [9:0] s);
        int n;
        n = 0;
        for (int i = 0; i < 10; i++) begin
            n = n + (s[i] ? 1 : -1);
        end
        return n;
    endfunction

    task automatic fail_now(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("Verification failed");
        $fatal(1, "check failed");
    endtask

    task automatic next_symbol();
        @(negedge pixel_clk);
        sym = tmds;
    endtask

    task automatic write_pixel(input int addr, input rgb_t px);
        @(negedge pixel_clk);
        fb_wr.we    = 1'b1;
        fb_wr.addr  = addr[`FB_ADDR_W-1:0];
        fb_wr.pixel = px;
        exp_mem[addr] = px;
        @(negedge pixel_clk);
        fb_wr = '0;
    endtask

    function automatic rgb_t random_pixel();
        rgb_t p;
        rng_state = xorshift(rng_state);
        p.red   = rng_state[23:16];
        p.green = rng_state[15:8];
        p.blue  = rng_state[7:0];
        return p;
    endfunction

    // leaves the stream just after the symbol where blue vsync falls
    task automatic wait_vsync_fall();
        logic       prev_v;
        logic       cur_v;
        logic [1:0] vh;
        prev_v = 1'b0;
        forever begin
            next_symbol();
            vh    = is_ctrl(sym.ch0) ? ctrl_syncs(sym.ch0) : 2'b00;
            cur_v = vh[1];
            if (prev_v && !cur_v) break;
            prev_v = cur_v;
        end
    endtask

    task automatic wait_vsync_rise();
        logic       cur_v;
        logic [1:0] vh;
        forever begin
            next_symbol();
            vh    = is_ctrl(sym.ch0) ? ctrl_syncs(sym.ch0) : 2'b00;
            cur_v = vh[1];
            if (cur_v) break;
        end
    endtask

    // checks one frame of active lines against exp_mem, plus line balance
    task automatic check_frame();
        int   n_data;
        int   bal [3];
        rgb_t got;
        wait_vsync_fall();
        // the fall is column 0 of the back porch line
        repeat (`H_TOTAL - 1) next_symbol();
        for (int y = 0; y < `V_ACTIVE; y++) begin
            // data symbols actually seen on this line
            n_data = 0;
            for (int x = 0; x < `H_TOTAL; x++) begin
                next_symbol();
                if (x < `H_ACTIVE) begin
                    if (!is_ctrl(sym.ch0) && !is_ctrl(sym.ch1) && !is_ctrl(sym.ch2)) begin
                        n_data++;
                        got.red   = decode_byte(sym.ch2);
                        got.green = decode_byte(sym.ch1);
                        got.blue  = decode_byte(sym.ch0);
                        assert (got == exp_mem[y * `H_ACTIVE + x])
                        else fail_now($sformatf("pixel (%0d,%0d) is %h, expected %h",
                                                x, y, got, exp_mem[y * `H_ACTIVE + x]));
                        bal[0] += ones_minus_zeros(sym.ch0);
                        bal[1] += ones_minus_zeros(sym.ch1);
                        bal[2] += ones_minus_zeros(sym.ch2);
                        for (int c = 0; c < 3; c++) begin
                            assert (bal[c] <= 10 && bal[c] >= -10)
                            else fail_now($sformatf("channel %0d balance %0d at (%0d,%0d)",
                                                    c, bal[c], x, y));
                        end
                    end
                end else begin
                    assert (is_ctrl(sym.ch0) && sym.ch1 == `CTRL_00 && sym.ch2 == `CTRL_00)
                    else fail_now($sformatf("bad blanking symbols at (%0d,%0d)", x, y));
                    // blanking restarts the count
                    bal = '{0, 0, 0};
                end
            end
            assert (n_data == `H_ACTIVE)
            else fail_now($sformatf("line %0d has %0d data symbols", y, n_data));
        end
    endtask

    task automatic test_reset();
        repeat (8) begin
            next_symbol();
            assert (sym.ch0 == `CTRL_00 && sym.ch1 == `CTRL_00 && sym.ch2 == `CTRL_00)
            else fail_now("symbols during reset are not CTRL_00");
        end
        // released at a falling edge, well away from the clock
        external_resetn = 1'b1;
        next_symbol();
        assert (sym.ch0 == `CTRL_00 && sym.ch1 == `CTRL_00 && sym.ch2 == `CTRL_00)
        else fail_now("first symbol after reset is not CTRL_00");
        next_symbol();
        assert (!is_ctrl(sym.ch0) && !is_ctrl(sym.ch1) && !is_ctrl(sym.ch2))
        else fail_now("pixel (0,0) did not arrive two cycles after reset");
    endtask

    task automatic test_sync_geometry();
        logic [1:0] vh;
        logic [1:0] prev;
        int h_run;
        int v_run;
        int h_rise;
        int v_rise;
        int n_v;
        prev   = 2'b00;
        h_run  = 0;
        v_run  = 0;
        h_rise = -1;
        v_rise = -1;
        n_v    = 0;
        for (int t = 0; t < 2 * FRAME_CYCLES + `H_TOTAL; t++) begin
            next_symbol();
            vh = is_ctrl(sym.ch0) ? ctrl_syncs(sym.ch0) : 2'b00;
            assert (is_ctrl(sym.ch0) == is_ctrl(sym.ch1) && is_ctrl(sym.ch0) == is_ctrl(sym.ch2))
            else fail_now("channels disagree on data versus blanking");
            if (is_ctrl(sym.ch0)) begin
                assert (sym.ch1 == `CTRL_00 && sym.ch2 == `CTRL_00)
                else fail_now("green or red not CTRL_00 in blanking");
            end
            if (vh[0] && !prev[0]) begin
                if (h_rise >= 0) begin
                    assert (t - h_rise == `H_TOTAL)
                    else fail_now($sformatf("hsync period %0d", t - h_rise));
                end
                h_rise = t;
                h_run  = 0;
            end
            if (!vh[0] && prev[0] && h_rise >= 0) begin
                assert (h_run == `H_SYNC)
                else fail_now($sformatf("hsync width %0d", h_run));
            end
            if (vh[1] && !prev[1]) begin
                if (v_rise >= 0) begin
                    assert (t - v_rise == FRAME_CYCLES)
                    else fail_now($sformatf("vsync period %0d", t - v_rise));
                end
                v_rise = t;
                v_run  = 0;
                n_v++;
            end
            if (!vh[1] && prev[1] && v_rise >= 0) begin
                assert (v_run == `V_SYNC * `H_TOTAL)
                else fail_now($sformatf("vsync width %0d", v_run));
            end
            h_run += vh[0];
            v_run += vh[1];
            prev = vh;
        end
        assert (n_v >= 2) else fail_now("fewer than two vsync pulses seen");
    endtask

    task automatic test_pixel_data();
        for (int a = 0; a < `FB_DEPTH; a++) begin
            write_pixel(a, random_pixel());
        end
        check_frame();
    endtask

    task automatic test_rewrite();
        wait_vsync_rise();
        write_pixel(0, random_pixel());
        write_pixel(37, random_pixel());
        write_pixel(90, random_pixel());
        write_pixel(`FB_DEPTH - 1, random_pixel());
        check_frame();
    endtask

    task automatic test_extreme_bytes();
        rgb_t p;
        for (int a = 0; a < `FB_DEPTH; a++) begin
            write_pixel(a, '{red: 8'h00, green: 8'hff, blue: 8'h00});
        end
        check_frame();
        for (int a = 0; a < `FB_DEPTH; a++) begin
            write_pixel(a, '{red: 8'hff, green: 8'h00, blue: 8'hff});
        end
        check_frame();
        // alternating per address, blue mixes in the full address
        for (int a = 0; a < `FB_DEPTH; a++) begin
            p.red   = a[0] ? 8'hff : 8'h00;
            p.green = a[0] ? 8'haa : 8'h55;
            p.blue  = 8'(a) ^ 8'ha5;
            write_pixel(a, p);
        end
        check_frame();
    endtask

    initial begin
        pixel_clk       = 1'b0;
        external_resetn = 1'b0;
        fb_wr           = '0;
        cycle_cnt       = 0;
        rng_state       = 32'd38;
        test_reset();
        test_sync_geometry();
        test_pixel_data();
        test_rewrite();
        test_extreme_bytes();
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+logic
logic/hdmi_pkg.sv
logic/video_timing.sv
logic/frame_buffer.sv
logic/tmds_encoder.sv
logic/hdmi_display_top.sv
dv/hdmi_display_sva.sv
dv/hdmi_display_tb.sv

// ==== logic/frame_buffer.sv ====
// dual-port pixel memory with strobed write and registered read
`default_nettype none

`include "hdmi_defines.svh"

module frame_buffer
    import hdmi_pkg::*;
(
    input  wire logic                  pixel_clk,
    input  wire fb_write_t             fb_wr_i,
    input  wire logic [`FB_ADDR_W-1:0] rd_addr_i,
    output rgb_t                       rd_pixel_o
);

    // one rgb word per active pixel
    rgb_t mem [`FB_DEPTH];

    // write port
    always_ff @(posedge pixel_clk) begin
        if (fb_wr_i.we) begin
            mem[fb_wr_i.addr] <= fb_wr_i.pixel;
        end
    end

    // read port, old data on a same-cycle write to the same address
    always_ff @(posedge pixel_clk) begin
        rd_pixel_o <= mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== logic/hdmi_defines.svh ====
// frame geometry, frame buffer size and tmds control symbols
`ifndef HDMI_DEFINES_SVH
`define HDMI_DEFINES_SVH

// horizontal geometry in pixels
`define H_ACTIVE 16
`define H_FRONT  2
`define H_SYNC   4
`define H_BACK   2
`define H_TOTAL  (`H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK)

// vertical geometry in lines
`define V_ACTIVE 8
`define V_FRONT  1
`define V_SYNC   2
`define V_BACK   1
`define V_TOTAL  (`V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK)

// frame buffer holds H_ACTIVE x V_ACTIVE words
`define FB_ADDR_W 7
`define FB_DEPTH  (`H_ACTIVE * `V_ACTIVE)

// control symbols, suffix is {vsync, hsync}
`define CTRL_00 10'b1101010100
`define CTRL_01 10'b0010101011
`define CTRL_10 10'b0101010100
`define CTRL_11 10'b1010101011

`endif

// ==== logic/hdmi_display_top.sv ====
// hdmi pixel path top with timing, frame buffer and three tmds encoders
`default_nettype none

`include "hdmi_defines.svh"

module hdmi_display_top
    import hdmi_pkg::*;
(
    input  wire logic      pixel_clk,
    input  wire logic      external_resetn,
    input  wire fb_write_t fb_wr_i,
    output tmds_sym_t      tmds_o
);

    logic [`FB_ADDR_W-1:0] rd_addr;
    sync_t                 sync;
    rgb_t                  rd_pixel;
    ctrl_bits_t            blue_ctrl;
    tmds_in_t              tin_blue;
    tmds_in_t              tin_green;
    tmds_in_t              tin_red;

    video_timing u_timing (
        .pixel_clk       (pixel_clk),
        .external_resetn (external_resetn),
        .sync_o          (sync),
        .rd_addr_o       (rd_addr)
    );

    frame_buffer u_fb (
        .pixel_clk  (pixel_clk),
        .fb_wr_i    (fb_wr_i),
        .rd_addr_i  (rd_addr),
        .rd_pixel_o (rd_pixel)
    );

    // syncs ride on the blue lane only
    assign blue_ctrl = '{pad: 6'b0, vsync: sync.vsync, hsync: sync.hsync};

    assign tin_blue.de    = sync.de;
    assign tin_blue.word  = sync.de ? rd_pixel.blue : blue_ctrl;
    assign tin_green.de   = sync.de;
    assign tin_green.word = sync.de ? rd_pixel.green : 8'h00;
    assign tin_red.de     = sync.de;
    assign tin_red.word   = sync.de ? rd_pixel.red : 8'h00;

    tmds_encoder u_enc_blue (
        .pixel_clk       (pixel_clk),
        .external_resetn (external_resetn),
        .tin_i           (tin_blue),
        .sym_o           (tmds_o.ch0)
    );

    tmds_encoder u_enc_green (
        .pixel_clk       (pixel_clk),
        .external_resetn (external_resetn),
        .tin_i           (tin_green),
        .sym_o           (tmds_o.ch1)
    );

    tmds_encoder u_enc_red (
        .pixel_clk       (pixel_clk),
        .external_resetn (external_resetn),
        .tin_i           (tin_red),
        .sym_o           (tmds_o.ch2)
    );

endmodule

`default_nettype wire

// ==== logic/hdmi_pkg.sv ====
// colour, frame buffer write, sync and tmds encoder types
`default_nettype none

`include "hdmi_defines.svh"

package hdmi_pkg;

    // one pixel, 8 bits per colour
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgb_t;

    // frame buffer write strobe
    typedef struct packed {
        logic                  we;
        logic [`FB_ADDR_W-1:0] addr;
        rgb_t                  pixel;
    } fb_write_t;

    typedef struct packed {
        logic de;
        logic hsync;
        logic vsync;
    } sync_t;

    // control view of an encoder input word
    typedef struct packed {
        logic [5:0] pad;
        logic       vsync;
        logic       hsync;
    } ctrl_bits_t;

    // pixel byte when de is high, control bits when de is low
    typedef union packed {
        logic [7:0] data;
        ctrl_bits_t ctrl;
    } tmds_word_u;

    typedef struct packed {
        logic       de;
        tmds_word_u word;
    } tmds_in_t;

    // ch0 is blue, ch1 green, ch2 red
    typedef struct packed {
        logic [9:0] ch2;
        logic [9:0] ch1;
        logic [9:0] ch0;
    } tmds_sym_t;

endpackage

`default_nettype wire

// ==== logic/tmds_encoder.sv ====
// tmds 8b/10b channel encoder with running disparity and control symbols
`default_nettype none

`include "hdmi_defines.svh"

module tmds_encoder
    import hdmi_pkg::*;
(
    input  wire logic     pixel_clk,
    input  wire logic     external_resetn,
    input  wire tmds_in_t tin_i,
    output logic [9:0]    sym_o
);

    logic [7:0]        d;
    logic [3:0]        n1_d;
    logic [3:0]        n1_q;
    logic [3:0]        n0_q;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic signed [4:0] balance;
    logic signed [4:0] disparity;
    logic signed [4:0] disparity_next;
    logic [9:0]        sym_next;

    function automatic logic [3:0] count_ones(input logic [7:0] v);
        logic [3:0] n;
        n = '0;
        for (int i = 0; i < 8; i++) begin
            n = n + {3'b000, v[i]};
        end
        return n;
    endfunction

    assign d    = tin_i.word.data;
    assign n1_d = count_ones(d);

    // xnor chain gives fewer transitions for bytes heavy in ones
    assign use_xnor = (n1_d > 4'd4) || ((n1_d == 4'd4) && !d[0]);

    always_comb begin
        q_m[0] = d[0];
        for (int i = 1; i < 8; i++) begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ d[i]) : (q_m[i-1] ^ d[i]);
        end
        q_m[8] = ~use_xnor;
    end

    assign n1_q    = count_ones(q_m[7:0]);
    assign n0_q    = 4'd8 - n1_q;
    // ones minus zeros of the chain output
    assign balance = $signed({1'b0, n1_q}) - $signed({1'b0, n0_q});

    always_comb begin
        sym_next       = `CTRL_00;
        disparity_next = disparity;
        if (!tin_i.de) begin
            // blanking, disparity starts over
            disparity_next = '0;
            case ({tin_i.word.ctrl.vsync, tin_i.word.ctrl.hsync})
                2'b00:   sym_next = `CTRL_00;
                2'b01:   sym_next = `CTRL_01;
                2'b10:   sym_next = `CTRL_10;
                default: sym_next = `CTRL_11;
            endcase
        end else if ((disparity == 0) || (balance == 0)) begin
            // no bias either way, bit 9 just flags xor vs xnor
            sym_next[9]   = ~q_m[8];
            sym_next[8]   = q_m[8];
            sym_next[7:0] = q_m[8] ? q_m[7:0] : ~q_m[7:0];
            if (q_m[8]) begin
                disparity_next = disparity + balance;
            end else begin
                disparity_next = disparity - balance;
            end
        end else if (((disparity > 0) && (balance > 0)) ||
                     ((disparity < 0) && (balance < 0))) begin
            // invert to pull the line back towards zero
            sym_next[9]    = 1'b1;
            sym_next[8]    = q_m[8];
            sym_next[7:0]  = ~q_m[7:0];
            disparity_next = disparity + (q_m[8] ? 5'sd2 : 5'sd0) - balance;
        end else begin
            sym_next[9]    = 1'b0;
            sym_next[8]    = q_m[8];
            sym_next[7:0]  = q_m[7:0];
            disparity_next = disparity - (q_m[8] ? 5'sd0 : 5'sd2) + balance;
        end
    end

    always_ff @(posedge pixel_clk or negedge external_resetn) begin
        if (!external_resetn) begin
            sym_o     <= `CTRL_00;
            disparity <= '0;
        end else begin
            sym_o     <= sym_next;
            disparity <= disparity_next;
        end
    end

endmodule

`default_nettype wire

// ==== logic/video_timing.sv ====
// video timing generator with raster counters, sync decode and frame buffer address
`default_nettype none

`include "hdmi_defines.svh"

module video_timing
    import hdmi_pkg::*;
(
    input  wire logic                  pixel_clk,
    input  wire logic                  external_resetn,
    output sync_t                      sync_o,
    output logic [`FB_ADDR_W-1:0]      rd_addr_o
);

    localparam int H_W = $clog2(`H_TOTAL);
    localparam int V_W = $clog2(`V_TOTAL);
    localparam int AW  = `FB_ADDR_W;

    // region boundaries at counter width
    localparam logic [H_W-1:0] H_ACT  = H_W'(`H_ACTIVE);
    localparam logic [H_W-1:0] HS_BEG = H_W'(`H_ACTIVE + `H_FRONT);
    localparam logic [H_W-1:0] HS_END = H_W'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam logic [H_W-1:0] H_LAST = H_W'(`H_TOTAL - 1);

    localparam logic [V_W-1:0] V_ACT  = V_W'(`V_ACTIVE);
    localparam logic [V_W-1:0] VS_BEG = V_W'(`V_ACTIVE + `V_FRONT);
    localparam logic [V_W-1:0] VS_END = V_W'(`V_ACTIVE + `V_FRONT + `V_SYNC);
    localparam logic [V_W-1:0] V_LAST = V_W'(`V_TOTAL - 1);

    logic [H_W-1:0] h_cnt;
    logic [V_W-1:0] v_cnt;
    logic           h_last;
    logic           v_last;
    sync_t          sync_c;

    assign h_last = (h_cnt == H_LAST);
    assign v_last = (v_cnt == V_LAST);

    // column counter wraps every line, line counter every frame
    always_ff @(posedge pixel_clk or negedge external_resetn) begin
        if (!external_resetn) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else begin
            if (h_last) begin
                h_cnt <= '0;
                if (v_last) begin
                    v_cnt <= '0;
                end else begin
                    v_cnt <= v_cnt + 1'b1;
                end
            end else begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // region decode for the current counter position
    assign sync_c.de    = (h_cnt < H_ACT) && (v_cnt < V_ACT);
    assign sync_c.hsync = (h_cnt >= HS_BEG) && (h_cnt < HS_END);
    assign sync_c.vsync = (v_cnt >= VS_BEG) && (v_cnt < VS_END);

    // linear address, row major, only meaningful inside the active area
    assign rd_addr_o = AW'(int'(v_cnt) * `H_ACTIVE + int'(h_cnt));

    // one stage to line up with the registered memory read
    always_ff @(posedge pixel_clk or negedge external_resetn) begin
        if (!external_resetn) begin
            sync_o <= '0;
        end else begin
            sync_o <= sync_c;
        end
    end

endmodule

`default_nettype wire
